//--- mac_rx_pkg.sv
// ******************************
// Shared widths and lane mask helpers for the MAC receive path
// Imported by the RTL stages and the testbench model
// ******************************
`default_nettype none

package mac_rx_pkg;

   // Word geometry of the 10G MAC side
   localparam int unsigned DATA_W = 64;
   localparam int unsigned STRB_W = 8;

   // Every lane valid, the word sits inside a frame
   localparam logic [STRB_W-1:0] FULL_MASK = {STRB_W{1'b1}};

   // ******************************
   // Mask helpers
   // ******************************

   // Any mask short of all ones closes the frame
   function automatic logic mask_is_end(input logic [STRB_W-1:0] mask);
      return mask != FULL_MASK;
   endfunction

   // No lane valid at all
   function automatic logic mask_is_null(input logic [STRB_W-1:0] mask);
      return mask == '0;
   endfunction

endpackage

`default_nettype wire

//--- rx_word_if.sv
// ******************************
// One decoded MAC word, from the decode stage to admission
// Per-cycle strobe, no back-pressure
// ******************************
`timescale 1ns/1ps
`default_nettype none

interface rx_word_if
   import mac_rx_pkg::*;
();

   logic              word_valid;
   logic [DATA_W-1:0] data;
   logic [STRB_W-1:0] strb;
   // Frame boundary flags
   logic              first;
   logic              last;

   modport decode (
      output word_valid, data, strb, first, last
   );

   modport admit (
      input  word_valid, data, strb, first, last
   );

endinterface

`default_nettype wire

//--- rx_fifo_wr_if.sv
// ******************************
// Write port of the stream buffer plus its fill status
// Driven by admission, free_count returned by the buffer
// ******************************
`timescale 1ns/1ps
`default_nettype none

interface rx_fifo_wr_if
   import mac_rx_pkg::*;
#(
   parameter int FIFO_DEPTH = 64
) ();

   logic                          wr_en;
   logic [DATA_W-1:0]             data;
   logic [STRB_W-1:0]             strb;
   logic                          last;
   // Free entries, one extra bit so an empty buffer fits
   logic [$clog2(FIFO_DEPTH):0]   free_count;

   modport admit (
      output wr_en, data, strb, last,
      input  free_count
   );

   modport fifo (
      input  wr_en, data, strb, last,
      output free_count
   );

endinterface

`default_nettype wire

//--- rx_lane_decode.sv
// ******************************
// Decode stage of the MAC receive path
// Registers each MAC word and uses the live mask as one word of
// lookahead to find the true last word of a frame
// ******************************
`timescale 1ns/1ps
`default_nettype none

module rx_lane_decode
   import mac_rx_pkg::*;
(
   input  wire                clk156,
   input  wire                reset,

   // MAC side
   input  wire [DATA_W-1:0]   rx_data,
   input  wire [STRB_W-1:0]   rx_data_valid,

   rx_word_if.decode          word
);

   // Word of the previous cycle
   logic [DATA_W-1:0] hold_data;
   logic [STRB_W-1:0] hold_strb;

   // A frame is open up to and including the previous held word
   logic              in_frame;
   logic              frame_word;
   logic              opens_frame;

   always_ff @(posedge clk156) begin
      hold_data <= rx_data;
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         hold_strb <= '0;
         in_frame  <= 1'b0;
      end else begin
         hold_strb <= rx_data_valid;
         // Stays open only while the held word is all ones
         in_frame  <= frame_word && !mask_is_end(hold_strb);
      end
   end

   // ******************************
   // Frame tracking
   // ******************************

   assign opens_frame = !in_frame && (hold_strb == FULL_MASK);

   // Partial or null words between frames belong to nothing
   assign frame_word = in_frame || opens_frame;

   // A null closer was already folded into the word before it
   assign word.word_valid = frame_word && !mask_is_null(hold_strb);
   assign word.first      = opens_frame;

   // Own mask ends the frame, or the next one carries no data
   assign word.last       = mask_is_end(hold_strb) || mask_is_null(rx_data_valid);

   assign word.data       = hold_data;
   assign word.strb       = hold_strb;

endmodule

`default_nettype wire

//--- rx_frame_admit.sv
// ******************************
// Admission stage, accepts or drops each whole frame
// A frame is only started when MAX_FRAME_WORDS entries are free
// ******************************
`timescale 1ns/1ps
`default_nettype none

module rx_frame_admit
#(
   parameter int FIFO_DEPTH      = 64,
   parameter int MAX_FRAME_WORDS = 16
)
(
   input  wire             clk156,
   input  wire             reset,

   rx_word_if.admit        word,
   rx_fifo_wr_if.admit     wr,

   output logic            frame_accepted,
   output logic            frame_dropped
);

   localparam logic [1:0] IDLE = 2'd0;
   localparam logic [1:0] PASS = 2'd1;
   localparam logic [1:0] DROP = 2'd2;

   localparam int CNT_W = $clog2(MAX_FRAME_WORDS) + 1;

   logic [1:0]       state;
   logic [1:0]       state_next;
   logic             room;

   // Words written so far in the current frame
   logic [CNT_W-1:0] frame_words;

   // Zero extend free_count before the compare
   assign room = 32'(wr.free_count) >= MAX_FRAME_WORDS;

   // ******************************
   // Frame FSM
   // ******************************

   always_comb begin
      state_next     = state;
      wr.wr_en       = 1'b0;
      frame_accepted = 1'b0;
      frame_dropped  = 1'b0;

      case (state)
         IDLE: begin
            if (word.word_valid && word.first) begin
               if (room) begin
                  wr.wr_en       = 1'b1;
                  frame_accepted = word.last;
                  state_next     = word.last ? IDLE : PASS;
               end else begin
                  frame_dropped  = 1'b1;
                  state_next     = word.last ? IDLE : DROP;
               end
            end
         end
         PASS: begin
            if (word.word_valid) begin
               wr.wr_en       = 1'b1;
               frame_accepted = word.last;
               if (word.last) begin
                  state_next = IDLE;
               end
            end
         end
         DROP: begin
            if (word.word_valid && word.last) begin
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         state       <= IDLE;
         frame_words <= '0;
      end else begin
         state <= state_next;
         if (wr.wr_en) begin
            frame_words <= word.first ? CNT_W'(1) : frame_words + 1'b1;
         end
      end
   end

   // Payload goes straight to the buffer
   assign wr.data = word.data;
   assign wr.strb = word.strb;
   assign wr.last = word.last;

   // Buffer status must keep every write in bounds
   a_no_write_when_full: assert property (@(posedge clk156) disable iff (reset)
      wr.wr_en |-> wr.free_count != '0);

   // Longer frames are outside the supported range
   a_frame_length: assert property (@(posedge clk156) disable iff (reset)
      (wr.wr_en && !word.first) |-> 32'(frame_words) < MAX_FRAME_WORDS);

endmodule

`default_nettype wire

//--- rx_stream_fifo.sv
// ******************************
// Synchronous first-word-fall-through buffer
// Head entry drives the AXI-Stream outputs directly, pops on transfer
// ******************************
`timescale 1ns/1ps
`default_nettype none

module rx_stream_fifo
   import mac_rx_pkg::*;
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  wire                clk156,
   input  wire                reset,

   rx_fifo_wr_if.fifo         wr,

   // AXI-Stream master
   output logic [DATA_W-1:0]  tdata,
   output logic [STRB_W-1:0]  tstrb,
   output logic               tvalid,
   output logic               tlast,
   input  wire                tready
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   // ******************************
   // Storage
   // ******************************

   logic [DATA_W-1:0] mem_data [FIFO_DEPTH];
   logic [STRB_W-1:0] mem_strb [FIFO_DEPTH];
   logic              mem_last [FIFO_DEPTH];

   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;

   logic              push;
   logic              pop;
   logic              full;

   assign full = count == CNT_W'(FIFO_DEPTH);
   assign push = wr.wr_en;
   assign pop  = tvalid && tready;

   always_ff @(posedge clk156) begin
      if (push) begin
         mem_data[wr_ptr] <= wr.data;
         mem_strb[wr_ptr] <= wr.strb;
         mem_last[wr_ptr] <= wr.last;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk156) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Status back to admission
   assign wr.free_count = CNT_W'(FIFO_DEPTH) - count;

   // ******************************
   // Stream side
   // ******************************

   assign tvalid = count != '0;
   assign tdata  = mem_data[rd_ptr];
   assign tstrb  = mem_strb[rd_ptr];
   assign tlast  = tvalid && mem_last[rd_ptr];

   // A stalled beat must hold until it transfers
   a_stall_stable: assert property (@(posedge clk156) disable iff (reset)
      (tvalid && !tready) |=>
         tvalid && $stable(tdata) && $stable(tstrb) && $stable(tlast));

   // Admission must never push into a full buffer
   a_no_overflow: assert property (@(posedge clk156) disable iff (reset)
      full |-> !wr.wr_en);

endmodule

`default_nettype wire

//--- rx_frame_stats.sv
// ******************************
// Accepted and dropped frame counters
// Fed by the single-cycle pulses of the admission stage
// ******************************
`timescale 1ns/1ps
`default_nettype none

module rx_frame_stats (
   input  wire          clk156,
   input  wire          reset,

   input  wire          frame_accepted,
   input  wire          frame_dropped,

   output logic [15:0]  frames_accepted,
   output logic [15:0]  frames_dropped
);

   // Both counters wrap at 16 bits
   always_ff @(posedge clk156) begin
      if (reset) begin
         frames_accepted <= '0;
      end else if (frame_accepted) begin
         frames_accepted <= frames_accepted + 1'b1;
      end
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         frames_dropped <= '0;
      end else if (frame_dropped) begin
         frames_dropped <= frames_dropped + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- mac_rx_top.sv
// ******************************
// Receive half of the 10G MAC to AXI-Stream converter
// MAC words in, AXI-Stream beats and frame counters out
// ******************************
`timescale 1ns/1ps
`default_nettype none

module mac_rx_top
   import mac_rx_pkg::*;
#(
   parameter int FIFO_DEPTH      = 64,
   parameter int MAX_FRAME_WORDS = 16
)
(
   input  wire                clk156,
   input  wire                reset,

   // MAC side
   input  wire [DATA_W-1:0]   rx_data,
   input  wire [STRB_W-1:0]   rx_data_valid,

   // AXI side
   output logic [DATA_W-1:0]  tdata,
   output logic [STRB_W-1:0]  tstrb,
   output logic               tvalid,
   output logic               tlast,
   input  wire                tready,

   // Stats
   output logic [15:0]        frames_accepted,
   output logic [15:0]        frames_dropped
);

   rx_word_if                                 word_bus ();
   rx_fifo_wr_if #(.FIFO_DEPTH(FIFO_DEPTH))   wr_bus ();

   wire frame_accepted;
   wire frame_dropped;

   rx_lane_decode decode0 (
      .clk156        (clk156),
      .reset         (reset),
      .rx_data       (rx_data),
      .rx_data_valid (rx_data_valid),
      .word          (word_bus.decode)
   );

   rx_frame_admit #(
      .FIFO_DEPTH      (FIFO_DEPTH),
      .MAX_FRAME_WORDS (MAX_FRAME_WORDS)
   ) admit0 (
      .clk156         (clk156),
      .reset          (reset),
      .word           (word_bus.admit),
      .wr             (wr_bus.admit),
      .frame_accepted (frame_accepted),
      .frame_dropped  (frame_dropped)
   );

   rx_stream_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo0 (
      .clk156 (clk156),
      .reset  (reset),
      .wr     (wr_bus.fifo),
      .tdata  (tdata),
      .tstrb  (tstrb),
      .tvalid (tvalid),
      .tlast  (tlast),
      .tready (tready)
   );

   rx_frame_stats stats0 (
      .clk156          (clk156),
      .reset           (reset),
      .frame_accepted  (frame_accepted),
      .frame_dropped   (frame_dropped),
      .frames_accepted (frames_accepted),
      .frames_dropped  (frames_dropped)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// ******************************
// Testbench clock and reset source
// 20 ns clk156, reset held high for the first 10 cycles
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic clk156,
   output logic reset
);

   initial begin
      clk156 = 1'b0;
      forever #HALF_PERIOD clk156 = ~clk156;
   end

   // Released on a falling edge like every other input
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk156);
      @(negedge clk156);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- tb_mac_rx.sv
// ******************************
// Testbench for the MAC receive path
// Drives MAC words on the falling edge, predicts accepted beats in a
// reference ring and checks the AXI side with concurrent assertions
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_mac_rx
   import mac_rx_pkg::*;
();

   localparam int FIFO_DEPTH      = 64;
   localparam int MAX_FRAME_WORDS = 16;

   wire               clk156;
   wire               reset;
   logic [DATA_W-1:0] rx_data;
   logic [STRB_W-1:0] rx_data_valid;
   logic              tready;
   wire  [DATA_W-1:0] tdata;
   wire  [STRB_W-1:0] tstrb;
   wire               tvalid;
   wire               tlast;
   wire  [15:0]       frames_accepted;
   wire  [15:0]       frames_dropped;

   logic [15:0]       lfsr;
   int                ready_mode;
   int                err_count;

   // Reference model state
   logic [DATA_W-1:0] m_prev_data;
   logic [STRB_W-1:0] m_prev_mask;
   logic              m_open;
   logic              m_take;
   logic              wrote_empty;
   int                m_fill;
   logic [15:0]       exp_accepted;
   logic [15:0]       exp_dropped;
   logic [15:0]       tlast_beats;
   logic [DATA_W-1:0] exp_data [256];
   logic [STRB_W-1:0] exp_strb [256];
   logic              exp_last [256];
   logic [7:0]        ring_wr;
   logic [7:0]        ring_rd;

   tb_clock_gen clk_gen0 (.clk156(clk156), .reset(reset));

   mac_rx_top #(
      .FIFO_DEPTH      (FIFO_DEPTH),
      .MAX_FRAME_WORDS (MAX_FRAME_WORDS)
   ) dut0 (
      .clk156 (clk156), .reset (reset),
      .rx_data (rx_data), .rx_data_valid (rx_data_valid),
      .tdata (tdata), .tstrb (tstrb), .tvalid (tvalid), .tlast (tlast), .tready (tready),
      .frames_accepted (frames_accepted), .frames_dropped (frames_dropped)
   );

   // ******************************
   // Helpers
   // ******************************

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic int random_length();
      return 1 + int'(4'(take_bits(4))) % (MAX_FRAME_WORDS - 1);
   endfunction

   task automatic flag_error(input string msg);
      $display("** Error: time %0t ns: %s", $time, msg);
      err_count++;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task automatic close_test(input int num, input string name);
      $display("test %0d %s finished, %0d errors so far", num, name, err_count);
   endtask

   // One MAC cycle, tready follows the current mode
   task automatic drive_cycle(input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] m);
      @(negedge clk156);
      rx_data       = d;
      rx_data_valid = m;
      case (ready_mode)
         0:       tready = 1'b0;
         1:       tready = 1'b1;
         default: tready = 1'(take_bits(1));
      endcase
   endtask

   // Full words, a partial or null closer, then one idle cycle
   task automatic send_frame(input int words, input logic null_end);
      logic [2:0] lanes;
      for (int i = 0; i < words; i++) begin
         drive_cycle(take_bits(DATA_W), FULL_MASK >> 0);
      end
      lanes = 3'(take_bits(3));
      if (null_end) begin
         drive_cycle(take_bits(DATA_W), '0);
      end else begin
         drive_cycle(take_bits(DATA_W), FULL_MASK >> (STRB_W - (int'(lanes) % 7 + 1)));
      end
      drive_cycle('0, '0);
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      // Look at reset only once the clock runs
      @(negedge clk156);
      while (reset && n < 40) begin
         @(negedge clk156);
         n++;
      end
      if (reset) abort_on_timeout("reset release");
   endtask

   // Two idle cycles flush the decode and admission pipeline first
   task automatic wait_drained();
      int n;
      n = 0;
      repeat (2) drive_cycle('0, '0);
      while ((ring_wr != ring_rd || tvalid) && n < 600) begin
         drive_cycle('0, '0);
         n++;
      end
      if (ring_wr != ring_rd || tvalid) abort_on_timeout("the AXI side to drain");
   endtask

   // ******************************
   // Reference model
   // ******************************

   always @(posedge clk156) begin
      logic opening;
      logic take;
      logic is_word;
      logic is_last;
      logic push;
      logic pop;
      opening = !m_open && (m_prev_mask == FULL_MASK);
      take    = opening ? (FIFO_DEPTH - m_fill >= MAX_FRAME_WORDS) : m_take;
      is_word = (m_open || opening) && !mask_is_null(m_prev_mask);
      // Lookahead on the live mask marks the true last word
      is_last = mask_is_end(m_prev_mask) || mask_is_null(rx_data_valid);
      push    = is_word && take;
      pop     = tvalid && tready;
      m_prev_data <= rx_data;
      if (reset) begin
         m_prev_mask  <= '0;
         m_open       <= 1'b0;
         m_take       <= 1'b0;
         m_fill       <= 0;
         wrote_empty  <= 1'b0;
         exp_accepted <= '0;
         exp_dropped  <= '0;
         tlast_beats  <= '0;
         ring_wr      <= '0;
         ring_rd      <= '0;
      end else begin
         m_prev_mask <= rx_data_valid;
         m_open      <= (m_open || opening) && !mask_is_end(m_prev_mask);
         m_take      <= take;
         m_fill      <= m_fill + int'(push) - int'(pop);
         wrote_empty <= push && (m_fill == 0);
         if (opening && !take) exp_dropped <= exp_dropped + 16'd1;
         if (push) begin
            exp_data[ring_wr] <= m_prev_data;
            exp_strb[ring_wr] <= m_prev_mask;
            exp_last[ring_wr] <= is_last;
            ring_wr           <= ring_wr + 8'd1;
            if (is_last) exp_accepted <= exp_accepted + 16'd1;
         end
         if (pop) ring_rd <= ring_rd + 8'd1;
         if (pop && tlast) tlast_beats <= tlast_beats + 16'd1;
      end
   end

   // ******************************
   // Checks
   // ******************************

   reset_state: assert property (@(posedge clk156)
      reset |=> !tvalid && !tlast && frames_accepted == '0 && frames_dropped == '0)
      else flag_error("outputs or counters not cleared by reset");

   beat_expected: assert property (@(posedge clk156) disable iff (reset)
      (tvalid && tready) |-> ring_wr != ring_rd)
      else flag_error("beat transferred with no expected word");

   beat_matches: assert property (@(posedge clk156) disable iff (reset)
      (tvalid && tready && ring_wr != ring_rd) |->
         tdata == exp_data[ring_rd] && tstrb == exp_strb[ring_rd] &&
         tlast == exp_last[ring_rd])
      else flag_error("beat differs from expected word");

   no_null_beat: assert property (@(posedge clk156) disable iff (reset)
      tvalid |-> tstrb != '0)
      else flag_error("beat with zero tstrb");

   stall_holds: assert property (@(posedge clk156) disable iff (reset)
      (tvalid && !tready) |=> tvalid && $stable(tdata) && $stable(tstrb) && $stable(tlast))
      else flag_error("stalled beat changed");

   head_latency: assert property (@(posedge clk156) disable iff (reset)
      wrote_empty |-> tvalid)
      else flag_error("word into empty buffer not shown on tvalid in time");

   counts_match: assert property (@(posedge clk156) disable iff (reset)
      frames_accepted == exp_accepted && frames_dropped == exp_dropped)
      else flag_error("frame counters differ from expected");

   // ******************************
   // Stimulus
   // ******************************

   initial begin
      int          n;
      logic [15:0] acc_before;
      logic [15:0] drop_before;
      rx_data       = '0;
      rx_data_valid = '0;
      tready        = 1'b0;
      ready_mode    = 0;
      err_count     = 0;
      lfsr          = 16'd80;

      wait_reset_release();
      close_test(1, "reset state");

      ready_mode = 1;
      for (int i = 0; i < 6; i++) send_frame(random_length(), 1'b0);
      wait_drained();
      close_test(2, "partial end word");

      send_frame(1, 1'b1);
      for (int i = 0; i < 5; i++) send_frame(random_length(), 1'b1);
      wait_drained();
      close_test(3, "null end word");

      ready_mode = 2;
      for (int i = 0; i < 12; i++) send_frame(random_length(), 1'(take_bits(1)));
      wait_drained();
      close_test(4, "random back-pressure");

      // Fill the buffer with tready low, then three frames must drop
      ready_mode = 0;
      n = 0;
      while (FIFO_DEPTH - m_fill >= MAX_FRAME_WORDS && n < 40) begin
         send_frame(random_length(), 1'(take_bits(1)));
         drive_cycle('0, '0);
         n++;
      end
      if (FIFO_DEPTH - m_fill >= MAX_FRAME_WORDS) abort_on_timeout("the buffer to fill");
      drop_before = frames_dropped;
      for (int i = 0; i < 3; i++) send_frame(random_length(), 1'b0);
      ready_mode = 1;
      wait_drained();
      assert (frames_dropped - drop_before == 16'd3)
         else flag_error("dropped frame count wrong after full buffer");
      assert (tlast_beats == frames_accepted)
         else flag_error("frames_accepted differs from tlast beats");
      close_test(5, "full buffer");

      acc_before  = frames_accepted;
      drop_before = frames_dropped;
      drive_cycle(take_bits(DATA_W), 8'h0f);
      drive_cycle(take_bits(DATA_W), 8'h00);
      drive_cycle(take_bits(DATA_W), 8'h01);
      drive_cycle(take_bits(DATA_W), 8'h7f);
      repeat (3) drive_cycle('0, '0);
      assert (frames_accepted == acc_before && frames_dropped == drop_before && !tvalid)
         else flag_error("words outside a frame changed the output");
      send_frame(random_length(), 1'b0);
      wait_drained();
      close_test(6, "words outside a frame");

      $display("6 tests run, %0d errors", err_count);
      if (err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
mac_rx_pkg.sv
rx_word_if.sv
rx_fifo_wr_if.sv
rx_lane_decode.sv
rx_frame_admit.sv
rx_stream_fifo.sv
rx_frame_stats.sv
mac_rx_top.sv
tb_clock_gen.sv
tb_mac_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run with Verilator, pass only if the log holds the pass message
cd "$(dirname "$0")" \
   && rm -f sim.log \
   && verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_mac_rx -f compile.f \
   && ./obj_dir/Vtb_mac_rx | tee sim.log \
   && grep -q "SIMULATION PASSED" sim.log \
   || { echo "simulation did not pass"; exit 1; }
